// ==== rtl/amber_pkg.sv ====
package amber_pkg;

    localparam int data_w    = 24;
    localparam int addr_w    = 12;
    localparam int reg_idx_w = 4;
    localparam int num_regs  = 16;

    localparam int opc_w = 4;
    localparam int imm_w = 12;

    // Lowest bit of each instruction field.
    localparam int opc_lsb = 20;
    localparam int rd_lsb  = 16;
    localparam int rs_lsb  = 12;
    localparam int rt_lsb  = 8;

    // An all-zero word decodes as NOP.
    localparam logic [data_w-1:0] nop_instr = '0;

    typedef enum logic [opc_w-1:0] {
        OPC_NOP  = 4'd0,
        OPC_ADD  = 4'd1,
        OPC_SUB  = 4'd2,
        OPC_AND  = 4'd3,
        OPC_OR   = 4'd4,
        OPC_XOR  = 4'd5,
        OPC_ADDI = 4'd6,  // rd = rs + sext(imm12).
        OPC_MOVI = 4'd7,  // rd = sext(imm12).
        OPC_BEQ  = 4'd8,  // Compares rd with rs.
        OPC_BNE  = 4'd9,
        OPC_JMP  = 4'd10  // Absolute target.
    } opc_e;

    // Opcodes 11 to 15 are reserved and treated as NOP by decode.

endpackage

// ==== rtl/amber_fetch.sv ====
`timescale 1ns/10ps

module amber_fetch import amber_pkg::*; (
    input  logic              iw_clk,
    input  logic              iw_rst,
    input  logic              branch_taken,
    input  logic [addr_w-1:0] branch_pc,
    output logic [addr_w-1:0] imem_addr,
    input  logic [data_w-1:0] imem_data,
    output logic [addr_w-1:0] if_pc,
    output logic [data_w-1:0] if_instr
);

    logic [addr_w-1:0] pc;

    assign imem_addr = pc;  // Memory answers in the same cycle.

    // Program counter and the instruction half of the stage register.
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pc       <= '0;
            if_instr <= nop_instr;
        end else if (branch_taken) begin
            pc       <= branch_pc;
            if_instr <= nop_instr;  // Drop the word fetched behind the branch.
        end else begin
            pc       <= pc + addr_w'(1);
            if_instr <= imem_data;
        end
    end

    always_ff @(posedge iw_clk) begin
        if_pc <= pc;
    end

endmodule

// ==== rtl/amber_gp_regs.sv ====
`timescale 1ns/10ps

module amber_gp_regs import amber_pkg::*; (
    input  logic                 iw_clk,
    input  logic                 iw_rst,
    input  logic [reg_idx_w-1:0] rd_addr_a,
    input  logic [reg_idx_w-1:0] rd_addr_b,
    output logic [data_w-1:0]    rd_data_a,
    output logic [data_w-1:0]    rd_data_b,
    input  logic                 wr_en,
    input  logic [reg_idx_w-1:0] wr_addr,
    input  logic [data_w-1:0]    wr_data
);

    logic [data_w-1:0] regs [num_regs];

    // R0 reads as zero and a write in flight bypasses the array.
    always_comb begin
        if (rd_addr_a == '0) begin
            rd_data_a = '0;
        end else if (wr_en && wr_addr == rd_addr_a) begin
            rd_data_a = wr_data;
        end else begin
            rd_data_a = regs[rd_addr_a];
        end
    end

    always_comb begin
        if (rd_addr_b == '0) begin
            rd_data_b = '0;
        end else if (wr_en && wr_addr == rd_addr_b) begin
            rd_data_b = wr_data;
        end else begin
            rd_data_b = regs[rd_addr_b];
        end
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// ==== rtl/amber_decode.sv ====
`timescale 1ns/10ps

module amber_decode import amber_pkg::*; (
    input  logic                 iw_clk,
    input  logic                 iw_rst,
    input  logic [addr_w-1:0]    if_pc,
    input  logic [data_w-1:0]    if_instr,
    output logic [reg_idx_w-1:0] rd_addr_a,
    output logic [reg_idx_w-1:0] rd_addr_b,
    input  logic [data_w-1:0]    rd_data_a,
    input  logic [data_w-1:0]    rd_data_b,
    input  logic                 flush,
    output opc_e                 ex_opc,
    output logic [reg_idx_w-1:0] ex_rd,
    output logic [reg_idx_w-1:0] ex_src_a,
    output logic [reg_idx_w-1:0] ex_src_b,
    output logic                 ex_we,
    output logic [data_w-1:0]    ex_a,
    output logic [data_w-1:0]    ex_b,
    output logic [data_w-1:0]    ex_imm,
    output logic [addr_w-1:0]    ex_pc
);

    logic [opc_w-1:0]     opc_raw;
    opc_e                 opc;
    logic [reg_idx_w-1:0] f_rd;
    logic [reg_idx_w-1:0] f_rs;
    logic [reg_idx_w-1:0] f_rt;
    logic [imm_w-1:0]     f_imm;
    logic                 is_branch;
    logic                 writes_rd;

    assign opc_raw = if_instr[opc_lsb +: opc_w];
    assign f_rd    = if_instr[rd_lsb +: reg_idx_w];
    assign f_rs    = if_instr[rs_lsb +: reg_idx_w];
    assign f_rt    = if_instr[rt_lsb +: reg_idx_w];
    assign f_imm   = if_instr[imm_w-1:0];

    always_comb begin
        if (opc_raw <= OPC_JMP) begin
            opc = opc_e'(opc_raw);
        end else begin
            opc = OPC_NOP;  // Reserved encodings.
        end
    end

    always_comb begin
        case (opc)
            OPC_ADD, OPC_SUB, OPC_AND, OPC_OR, OPC_XOR,
            OPC_ADDI, OPC_MOVI: writes_rd = (f_rd != '0);
            default:            writes_rd = 1'b0;
        endcase
    end

    assign is_branch = (opc == OPC_BEQ) || (opc == OPC_BNE);

    // Branches compare rd with rs.
    assign rd_addr_a = is_branch ? f_rd : f_rs;
    assign rd_addr_b = is_branch ? f_rs : f_rt;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            ex_opc <= OPC_NOP;
            ex_we  <= 1'b0;
        end else if (flush) begin
            ex_opc <= OPC_NOP;
            ex_we  <= 1'b0;
        end else begin
            ex_opc <= opc;
            ex_we  <= writes_rd;
        end
    end

    always_ff @(posedge iw_clk) begin
        ex_rd    <= f_rd;
        ex_src_a <= rd_addr_a;
        ex_src_b <= rd_addr_b;
        ex_a     <= rd_data_a;
        ex_b     <= rd_data_b;
        ex_imm   <= {{(data_w-imm_w){f_imm[imm_w-1]}}, f_imm};
        ex_pc    <= if_pc;
    end

endmodule

// ==== rtl/amber_execute.sv ====
`timescale 1ns/10ps

module amber_execute import amber_pkg::*; (
    input  logic                 iw_clk,
    input  logic                 iw_rst,
    input  opc_e                 ex_opc,
    input  logic [reg_idx_w-1:0] ex_rd,
    input  logic [reg_idx_w-1:0] ex_src_a,
    input  logic [reg_idx_w-1:0] ex_src_b,
    input  logic                 ex_we,
    input  logic [data_w-1:0]    ex_a,
    input  logic [data_w-1:0]    ex_b,
    input  logic [data_w-1:0]    ex_imm,
    input  logic [addr_w-1:0]    ex_pc,
    output logic                 branch_taken,
    output logic [addr_w-1:0]    branch_pc,
    output logic                 wb_we,
    output logic [reg_idx_w-1:0] wb_addr,
    output logic [data_w-1:0]    wb_data
);

    logic [data_w-1:0] op_a;
    logic [data_w-1:0] op_b;
    logic [data_w-1:0] result;
    logic [addr_w-1:0] offset;

    // Distance-one bypass from the writeback register.
    // Longer distances are covered by the register file.
    assign op_a = (wb_we && wb_addr == ex_src_a) ? wb_data : ex_a;
    assign op_b = (wb_we && wb_addr == ex_src_b) ? wb_data : ex_b;

    always_comb begin
        case (ex_opc)
            OPC_ADD:  result = op_a + op_b;
            OPC_SUB:  result = op_a - op_b;
            OPC_AND:  result = op_a & op_b;
            OPC_OR:   result = op_a | op_b;
            OPC_XOR:  result = op_a ^ op_b;
            OPC_ADDI: result = op_a + ex_imm;
            OPC_MOVI: result = ex_imm;
            default:  result = '0;
        endcase
    end

    always_comb begin
        case (ex_opc)
            OPC_BEQ: branch_taken = (op_a == op_b);
            OPC_BNE: branch_taken = (op_a != op_b);
            OPC_JMP: branch_taken = 1'b1;
            default: branch_taken = 1'b0;
        endcase
    end

    assign offset = ex_imm[addr_w-1:0];

    // JMP is absolute and conditional branches are PC relative.
    assign branch_pc = (ex_opc == OPC_JMP) ? offset : ex_pc + offset;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= ex_we;
        end
    end

    always_ff @(posedge iw_clk) begin
        wb_addr <= ex_rd;
        wb_data <= result;
    end

endmodule

// ==== rtl/amber_core.sv ====
`timescale 1ns/10ps

module amber_core import amber_pkg::*; (
    input  logic                 iw_clk,
    input  logic                 iw_rst,
    output logic [addr_w-1:0]    imem_addr,
    input  logic [data_w-1:0]    imem_data,
    output logic                 wb_we,
    output logic [reg_idx_w-1:0] wb_addr,
    output logic [data_w-1:0]    wb_data
);

    logic                 branch_taken;
    logic [addr_w-1:0]    branch_pc;
    logic [addr_w-1:0]    if_pc;
    logic [data_w-1:0]    if_instr;
    logic [reg_idx_w-1:0] rd_addr_a;
    logic [reg_idx_w-1:0] rd_addr_b;
    logic [data_w-1:0]    rd_data_a;
    logic [data_w-1:0]    rd_data_b;
    opc_e                 ex_opc;
    logic [reg_idx_w-1:0] ex_rd;
    logic [reg_idx_w-1:0] ex_src_a;
    logic [reg_idx_w-1:0] ex_src_b;
    logic                 ex_we;
    logic [data_w-1:0]    ex_a;
    logic [data_w-1:0]    ex_b;
    logic [data_w-1:0]    ex_imm;
    logic [addr_w-1:0]    ex_pc;

    amber_fetch u_fetch (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .if_pc        (if_pc),
        .if_instr     (if_instr)
    );

    amber_decode u_decode (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .if_pc     (if_pc),
        .if_instr  (if_instr),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .flush     (branch_taken),  // Kills the instruction behind the branch.
        .ex_opc    (ex_opc),
        .ex_rd     (ex_rd),
        .ex_src_a  (ex_src_a),
        .ex_src_b  (ex_src_b),
        .ex_we     (ex_we),
        .ex_a      (ex_a),
        .ex_b      (ex_b),
        .ex_imm    (ex_imm),
        .ex_pc     (ex_pc)
    );

    amber_gp_regs u_gp_regs (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wb_we),
        .wr_addr   (wb_addr),
        .wr_data   (wb_data)
    );

    amber_execute u_execute (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .ex_opc       (ex_opc),
        .ex_rd        (ex_rd),
        .ex_src_a     (ex_src_a),
        .ex_src_b     (ex_src_b),
        .ex_we        (ex_we),
        .ex_a         (ex_a),
        .ex_b         (ex_b),
        .ex_imm       (ex_imm),
        .ex_pc        (ex_pc),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc),
        .wb_we        (wb_we),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data)
    );

endmodule

// ==== bench/amber_assert.sv ====
`timescale 1ns/10ps

module amber_assert import amber_pkg::*; (
    input logic                 iw_clk,
    input logic                 iw_rst,
    input logic                 wb_we,
    input logic [reg_idx_w-1:0] wb_addr,
    input logic                 branch_taken
);

    no_write_in_reset: assert property (@(posedge iw_clk) iw_rst |-> !wb_we)
        else $error("wb_we high during reset");

    // R0 writes are dropped in decode.
    no_r0_write: assert property (@(posedge iw_clk) disable iff (iw_rst)
        wb_we |-> wb_addr != '0)
        else $error("write to r0 reached writeback");

    // Two flushed slots follow a taken branch.
    flush_after_branch: assert property (@(posedge iw_clk) disable iff (iw_rst)
        branch_taken |-> ##2 !wb_we ##1 !wb_we)
        else $error("flushed instruction committed after taken branch");

endmodule

bind amber_core amber_assert u_assert (
    .iw_clk       (iw_clk),
    .iw_rst       (iw_rst),
    .wb_we        (wb_we),
    .wb_addr      (wb_addr),
    .branch_taken (branch_taken)
);

// ==== bench/amber_tb.sv ====
`timescale 1ns/10ps

module amber_tb import amber_pkg::*; ();

    localparam int prog_len   = 200;
    localparam int chain_len  = 24;  // Forwarding chains sit at the start.
    localparam int wait_limit = 5000;

    logic                 iw_clk;
    logic                 iw_rst;
    logic [addr_w-1:0]    imem_addr;
    logic [data_w-1:0]    imem_data;
    logic                 wb_we;
    logic [reg_idx_w-1:0] wb_addr;
    logic [data_w-1:0]    wb_data;

    logic [data_w-1:0]    imem [4096];
    logic [reg_idx_w-1:0] exp_addr [$];
    logic [data_w-1:0]    exp_data [$];
    bit                   exp_fwd [$];
    logic [addr_w-1:0]    br_target [$];
    int err_fetch = 0;
    int err_alu = 0;
    int err_fwd = 0;
    int err_br = 0;
    int err_extra = 0;
    int n_alu = 0;
    int n_fwd = 0;
    int first_br = prog_len;
    int tests_failed = 0;
    bit br_pending = 0;
    logic [addr_w-1:0] br_expect;

    amber_core uut (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_we     (wb_we),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

    assign imem_data = imem[imem_addr];  // Same-cycle read.

    initial begin
        iw_clk = 1'b0;
        forever #5 iw_clk = ~iw_clk;
    end

    function automatic logic [data_w-1:0] make_word(input logic [3:0] opc, input logic [3:0] rd,
                                                    input logic [3:0] rs, input logic [11:0] low);
        return (data_w'(opc) << opc_lsb) | (data_w'(rd) << rd_lsb) |
               (data_w'(rs) << rs_lsb) | data_w'(low);
    endfunction

    function automatic logic [data_w-1:0] sext12(input logic [11:0] v);
        return {{(data_w-12){v[11]}}, v};
    endfunction

    task automatic build_program();
        int pc;
        int off;
        logic [3:0] ra, rb, rc, rx, opc;
        for (int a = 0; a < 4096; a++) begin
            imem[a] = make_word(OPC_JMP, 4'd0, 4'd0, a[11:0]);  // Self-jump everywhere.
        end
        for (int g = 0; g < chain_len / 4; g++) begin
            ra = 4'($urandom_range(1, 15));
            rb = 4'($urandom_range(1, 15));
            rc = 4'($urandom_range(1, 15));
            rx = 4'($urandom_range(1, 15));
            imem[g*4]   = make_word(OPC_MOVI, ra, 4'd0, 12'($urandom));
            imem[g*4+1] = make_word(OPC_ADD, rb, ra, {ra, 8'h00});
            imem[g*4+2] = make_word(OPC_SUB, rc, ra, {rb, 8'h00});
            imem[g*4+3] = make_word(OPC_XOR, rx, ra, {rc, 8'h00});
        end
        for (pc = chain_len; pc < prog_len; pc++) begin
            opc = 4'($urandom_range(0, 15));
            off = $urandom_range(1, 8);
            if (pc + off > prog_len) off = prog_len - pc;
            if (opc == OPC_BEQ || opc == OPC_BNE) begin
                imem[pc] = make_word(opc, 4'($urandom), 4'($urandom), 12'(off));
            end else if (opc == OPC_JMP) begin
                imem[pc] = make_word(opc, 4'd0, 4'd0, 12'(pc + off));
            end else begin
                imem[pc] = make_word(opc, 4'($urandom), 4'($urandom), 12'($urandom));
            end
        end
        imem[prog_len] = make_word(OPC_JMP, 4'd0, 4'd0, 12'(prog_len));
    endtask

    // ISA-level model that runs the program in order up to the final self-jump.
    task automatic run_model();
        logic [data_w-1:0] r [16];
        logic [data_w-1:0] w, res, va, vb;
        logic [3:0] opc, rd, rs, rt;
        int pc = 0;
        int steps = 0;
        bit wr, tk;
        for (int i = 0; i < 16; i++) r[i] = '0;
        while (pc != prog_len && steps < 2000) begin
            w = imem[pc];
            opc = w[opc_lsb +: 4];
            rd = w[rd_lsb +: 4];
            rs = w[rs_lsb +: 4];
            rt = w[rt_lsb +: 4];
            va = r[rs];
            vb = r[rt];
            wr = 1'b1;
            tk = 1'b0;
            res = '0;
            case (opc)
                OPC_ADD:  res = va + vb;
                OPC_SUB:  res = va - vb;
                OPC_AND:  res = va & vb;
                OPC_OR:   res = va | vb;
                OPC_XOR:  res = va ^ vb;
                OPC_ADDI: res = va + sext12(w[11:0]);
                OPC_MOVI: res = sext12(w[11:0]);
                default:  wr = 1'b0;
            endcase
            if (wr && rd != 0) begin
                r[rd] = res;
                exp_addr.push_back(rd);
                exp_data.push_back(res);
                exp_fwd.push_back(pc < chain_len);
                if (pc < chain_len) n_fwd++;
                else n_alu++;
            end
            if (opc == OPC_BEQ) tk = (r[rd] == r[rs]);
            if (opc == OPC_BNE) tk = (r[rd] != r[rs]);
            if (opc == OPC_JMP) tk = 1'b1;
            if (tk) begin
                if (br_target.size() == 0) first_br = pc;
                pc = (opc == OPC_JMP) ? int'(w[11:0]) : int'(addr_w'(pc + w[11:0]));
                br_target.push_back(addr_w'(pc));
            end else begin
                pc++;
            end
            steps++;
        end
    endtask

    always @(negedge iw_clk) begin
        if (!iw_rst && wb_we) begin
            assert (exp_addr.size() > 0) else begin
                $display("Register write to r%0d at %0t ns after the program finished",
                         wb_addr, $time);
                err_extra++;
            end
            if (exp_addr.size() > 0) begin
                assert (wb_addr == exp_addr[0] && wb_data == exp_data[0]) else begin
                    $display("Error: %0t ns write r%0d=%h, expected r%0d=%h", $time,
                             wb_addr, wb_data, exp_addr[0], exp_data[0]);
                    if (exp_fwd[0]) err_fwd++;
                    else err_alu++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                void'(exp_fwd.pop_front());
            end
        end
    end

    always @(negedge iw_clk) begin
        if (br_pending) begin
            assert (imem_addr == br_expect) else begin
                $display("Error: %0t ns fetch after branch at %h, expected %h", $time,
                         imem_addr, br_expect);
                err_br++;
            end
            br_pending = 0;
        end
        if (!iw_rst && uut.branch_taken && br_target.size() > 0) begin
            br_expect = br_target.pop_front();
            br_pending = 1;
        end
    end

    task automatic report(input int num, input string name, input bit ok);
        if (ok) begin
            $display("Test %0d %s: PASS", num, name);
        end else begin
            $display("Test %0d %s: FAIL", num, name);
            tests_failed++;
        end
    endtask

    initial begin
        int cyc;
        iw_rst = 1'b1;
        void'($urandom(32'hbdf80fcf));
        build_program();
        run_model();
        repeat (16) begin
            @(negedge iw_clk);
            assert (!wb_we) else begin
                $display("Error: %0t ns wb_we high during reset", $time);
                err_fetch++;
            end
        end
        @(posedge iw_clk);
        iw_rst <= 1'b0;
        for (int k = 0; k <= first_br + 2 && k < 300; k++) begin
            @(negedge iw_clk);
            assert (imem_addr == addr_w'(k)) else begin
                $display("Error: %0t ns imem_addr %h, expected %h", $time, imem_addr, k);
                err_fetch++;
            end
        end
        report(1, "reset and sequential fetch", err_fetch == 0);
        cyc = 0;
        while (exp_addr.size() > 0 && cyc < wait_limit) begin
            @(negedge iw_clk);
            cyc++;
        end
        if (exp_addr.size() > 0) begin
            $display("Timed out with %0d register writes still missing", exp_addr.size());
        end
        cyc = 0;
        while (cyc < 20) begin
            @(negedge iw_clk);
            cyc++;
        end
        report(2, "ALU and immediate results", err_alu == 0 && n_alu > 0);
        report(3, "forwarding chains", err_fwd == 0 && n_fwd > 0);
        report(4, "branch redirect and flush", err_br == 0 && br_target.size() == 0);
        report(5, "completion", exp_addr.size() == 0 && err_extra == 0);
        $display("Tests: %0d passed, %0d failed", 5 - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/amber_pkg.sv
rtl/amber_fetch.sv
rtl/amber_gp_regs.sv
rtl/amber_decode.sv
rtl/amber_execute.sv
rtl/amber_core.sv
bench/amber_assert.sv
bench/amber_tb.sv
